//--- hw/cdc_bridge_pkg.sv
`default_nettype none

package cdc_bridge_pkg;

    // data widths
    localparam int BYTE_W = 8;
    localparam int WORD_W = 2 * BYTE_W;     // byte 0 in the low half

    // fifo geometry
    localparam int FIFO_DEPTH = 16;
    localparam int ADDR_W     = $clog2(FIFO_DEPTH);  // pointers carry one more bit

    // entry layout: {last, one_byte, data}
    localparam int ENTRY_W        = WORD_W + 2;
    localparam int ENTRY_ONE_BIT  = WORD_W;       // only byte 0 is valid
    localparam int ENTRY_LAST_BIT = WORD_W + 1;   // entry closes a packet

    // read-side unpacker states
    localparam int             UNP_STATE_W = 2;
    localparam logic [1:0]     UNP_IDLE    = 2'd0;
    localparam logic [1:0]     UNP_FETCH   = 2'd1;
    localparam logic [1:0]     UNP_EMIT_LO = 2'd2;
    localparam logic [1:0]     UNP_EMIT_HI = 2'd3;

endpackage

`default_nettype wire

//--- hw/byte_pair_packer.sv
`timescale 1ns/1ps
`default_nettype none

module byte_pair_packer (
    input  logic                               wr_clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  logic [cdc_bridge_pkg::BYTE_W-1:0]  in_data,
    input  logic                               in_last,
    input  logic                               fifo_full,
    output logic                               fifo_wr_en,
    output logic [cdc_bridge_pkg::ENTRY_W-1:0] fifo_wr_data,
    output logic                               overflow
);

    logic [cdc_bridge_pkg::BYTE_W-1:0]  low_byte;    // first byte of a pair
    logic                               half_full;   // low_byte is waiting for a partner
    logic                               entry_done;  // this byte closes an entry
    logic [cdc_bridge_pkg::ENTRY_W-1:0] entry;

    // second byte of a pair, or a last byte, finishes the entry
    assign entry_done = in_valid && (half_full || in_last);

    always_comb begin
        entry = '0;
        if (half_full) begin
            entry[cdc_bridge_pkg::WORD_W-1:0] = {in_data, low_byte};
        end else begin
            // packet ended on an odd byte
            entry[cdc_bridge_pkg::BYTE_W-1:0]    = in_data;
            entry[cdc_bridge_pkg::ENTRY_ONE_BIT] = 1'b1;
        end
        entry[cdc_bridge_pkg::ENTRY_LAST_BIT] = in_last;
    end

    // control state
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            half_full  <= 1'b0;
            fifo_wr_en <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            fifo_wr_en <= entry_done && !fifo_full;  // one cycle after completion
            if (in_valid) begin
                half_full <= !half_full && !in_last;
            end
            // drop on full at completion
            if (entry_done && fifo_full) begin
                overflow <= 1'b1;
            end
            // a write already in flight that meets full is refused by the fifo
            if (fifo_wr_en && fifo_full) begin
                overflow <= 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge wr_clk) begin
        if (in_valid && !half_full) begin
            low_byte <= in_data;
        end
        if (entry_done) begin
            fifo_wr_data <= entry;
        end
    end

endmodule

`default_nettype wire

//--- hw/gray_ptr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_fifo (
    input  logic                               wr_clk,
    input  logic                               rd_clk,
    input  logic                               rst_n,
    input  logic                               wr_en,
    input  logic [cdc_bridge_pkg::ENTRY_W-1:0] wr_data,
    input  logic                               rd_en,
    output logic [cdc_bridge_pkg::ENTRY_W-1:0] rd_data,
    output logic                               full,
    output logic                               empty
);

    // storage, no reset
    logic [cdc_bridge_pkg::ENTRY_W-1:0] mem [0:cdc_bridge_pkg::FIFO_DEPTH-1];

    // write domain pointers
    logic [cdc_bridge_pkg::ADDR_W:0] wr_bin;
    logic [cdc_bridge_pkg::ADDR_W:0] wr_bin_next;
    logic [cdc_bridge_pkg::ADDR_W:0] wr_gray;

    // read domain pointers
    logic [cdc_bridge_pkg::ADDR_W:0] rd_bin;
    logic [cdc_bridge_pkg::ADDR_W:0] rd_bin_next;
    logic [cdc_bridge_pkg::ADDR_W:0] rd_gray;

    // two-flop synchronizer stages
    logic [cdc_bridge_pkg::ADDR_W:0] wr_gray_meta;  // first flop in rd_clk
    logic [cdc_bridge_pkg::ADDR_W:0] wr_gray_sync;  // usable in rd_clk
    logic [cdc_bridge_pkg::ADDR_W:0] rd_gray_meta;  // first flop in wr_clk
    logic [cdc_bridge_pkg::ADDR_W:0] rd_gray_sync;  // usable in wr_clk

    logic wr_accept;
    logic rd_accept;

    function automatic logic [cdc_bridge_pkg::ADDR_W:0] bin2gray(
        input logic [cdc_bridge_pkg::ADDR_W:0] bin
    );
        return bin ^ (bin >> 1);
    endfunction

    assign wr_accept   = wr_en && !full;   // writes ignored when full
    assign rd_accept   = rd_en && !empty;  // reads ignored when empty
    assign wr_bin_next = wr_bin + 1'b1;
    assign rd_bin_next = rd_bin + 1'b1;

    // write side
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_accept) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= bin2gray(wr_bin_next);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_accept) begin
            mem[wr_bin[cdc_bridge_pkg::ADDR_W-1:0]] <= wr_data;
        end
    end

    // read side
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (rd_accept) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= bin2gray(rd_bin_next);
        end
    end

    // registered read port, valid the cycle after the pop
    always_ff @(posedge rd_clk) begin
        if (rd_accept) begin
            rd_data <= mem[rd_bin[cdc_bridge_pkg::ADDR_W-1:0]];
        end
    end

    // write pointer into the read domain
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    // read pointer into the write domain
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    assign empty = (rd_gray == wr_gray_sync);

    // one lap ahead: top two gray bits differ, rest equal
    assign full = (wr_gray == {~rd_gray_sync[cdc_bridge_pkg::ADDR_W:cdc_bridge_pkg::ADDR_W-1],
                               rd_gray_sync[cdc_bridge_pkg::ADDR_W-2:0]});

endmodule

`default_nettype wire

//--- hw/byte_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module byte_unpacker (
    input  logic                               rd_clk,
    input  logic                               rst_n,
    input  logic                               fifo_empty,
    output logic                               fifo_rd_en,
    input  logic [cdc_bridge_pkg::ENTRY_W-1:0] fifo_rd_data,
    output logic                               out_valid,
    output logic [cdc_bridge_pkg::BYTE_W-1:0]  out_data,
    output logic                               out_last
);

    logic [cdc_bridge_pkg::UNP_STATE_W-1:0] state;
    logic                                   one_byte;   // entry holds byte 0 only
    logic                                   entry_last; // entry closes a packet

    // rd_data only changes on a pop, so it holds through both emit states
    assign one_byte   = fifo_rd_data[cdc_bridge_pkg::ENTRY_ONE_BIT];
    assign entry_last = fifo_rd_data[cdc_bridge_pkg::ENTRY_LAST_BIT];

    // pop only from idle
    assign fifo_rd_en = (state == cdc_bridge_pkg::UNP_IDLE) && !fifo_empty;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cdc_bridge_pkg::UNP_IDLE;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            case (state)
                cdc_bridge_pkg::UNP_IDLE: begin
                    if (!fifo_empty) begin
                        state <= cdc_bridge_pkg::UNP_FETCH;
                    end
                end
                cdc_bridge_pkg::UNP_FETCH: begin
                    // registered entry arrives this cycle
                    out_valid <= 1'b1;
                    out_last  <= one_byte && entry_last;
                    state     <= cdc_bridge_pkg::UNP_EMIT_LO;
                end
                cdc_bridge_pkg::UNP_EMIT_LO: begin
                    if (one_byte) begin
                        out_valid <= 1'b0;
                        out_last  <= 1'b0;
                        state     <= cdc_bridge_pkg::UNP_IDLE;
                    end else begin
                        out_valid <= 1'b1;
                        out_last  <= entry_last;  // high byte is the final one
                        state     <= cdc_bridge_pkg::UNP_EMIT_HI;
                    end
                end
                default: begin
                    out_valid <= 1'b0;
                    out_last  <= 1'b0;
                    state     <= cdc_bridge_pkg::UNP_IDLE;
                end
            endcase
        end
    end

    // byte select
    always_ff @(posedge rd_clk) begin
        if (state == cdc_bridge_pkg::UNP_FETCH) begin
            out_data <= fifo_rd_data[cdc_bridge_pkg::BYTE_W-1:0];
        end else if (state == cdc_bridge_pkg::UNP_EMIT_LO) begin
            out_data <= fifo_rd_data[cdc_bridge_pkg::WORD_W-1:cdc_bridge_pkg::BYTE_W];
        end
    end

endmodule

`default_nettype wire

//--- hw/cdc_byte_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_byte_bridge (
    input  logic                              wr_clk,
    input  logic                              rd_clk,
    input  logic                              rst_n,     // resets both domains
    // write side, wr_clk
    input  logic                              in_valid,
    input  logic [cdc_bridge_pkg::BYTE_W-1:0] in_data,
    input  logic                              in_last,
    output logic                              overflow,  // sticky until reset
    // read side, rd_clk
    output logic                              out_valid,
    output logic [cdc_bridge_pkg::BYTE_W-1:0] out_data,
    output logic                              out_last
);

    logic                               fifo_wr_en;
    logic [cdc_bridge_pkg::ENTRY_W-1:0] fifo_wr_data;
    logic                               fifo_full;
    logic                               fifo_rd_en;
    logic [cdc_bridge_pkg::ENTRY_W-1:0] fifo_rd_data;
    logic                               fifo_empty;

    byte_pair_packer u_packer (
        .wr_clk       (wr_clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_last      (in_last),
        .fifo_full    (fifo_full),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .overflow     (overflow)
    );

    gray_ptr_fifo u_fifo (
        .wr_clk  (wr_clk),
        .rd_clk  (rd_clk),
        .rst_n   (rst_n),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    byte_unpacker u_unpacker (
        .rd_clk       (rd_clk),
        .rst_n        (rst_n),
        .fifo_empty   (fifo_empty),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_last     (out_last)
    );

endmodule

`default_nettype wire

//--- verif/tb_cdc_byte_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_byte_bridge;

    localparam int BURST_BYTES    = 200;
    localparam int MAX_BYTES      = 24 + 17 + 30 * 8 + BURST_BYTES;
    localparam int TIMEOUT_CYCLES = MAX_BYTES * 8 + 2000;

    logic                              wr_clk;
    logic                              rd_clk;
    logic                              rst_n;
    logic                              in_valid;
    logic [cdc_bridge_pkg::BYTE_W-1:0] in_data;
    logic                              in_last;
    logic                              overflow;
    logic                              out_valid;
    logic [cdc_bridge_pkg::BYTE_W-1:0] out_data;
    logic                              out_last;

    logic [17:0] exp_q[$];       // {last, two bytes, byte 1, byte 0}
    logic        pend_valid;     // model holds a lone first byte
    logic [7:0]  pend_byte;
    logic        second_pos;     // next output is byte 1 of head entry
    logic [7:0]  exp_data;
    logic        exp_last;
    logic        have_exp;
    logic        skip_mode;      // whole entries may be missing
    logic        idle_check;
    logic        low_ovf_check;
    logic        high_ovf_check;
    logic        quiet_check;
    logic [31:0] lfsr;
    logic [7:0]  next_data;      // running byte value, unique per 256
    int          errors;
    int          bytes_in;
    int          bytes_out;
    int          cycle_count;

    initial begin
        rd_clk = 1'b0;
        forever #2 rd_clk = ~rd_clk;
    end

    initial begin
        wr_clk = 1'b0;
        forever #3 wr_clk = ~wr_clk;
    end

    cdc_byte_bridge u_dut (
        .wr_clk    (wr_clk),
        .rd_clk    (rd_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_last   (in_last),
        .overflow  (overflow),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    // pairs bytes, a last byte on its own becomes a one-byte entry
    task automatic expect_byte(input logic [7:0] d, input logic last);
        if (pend_valid) begin
            exp_q.push_back({last, 1'b1, d, pend_byte});
            pend_valid = 1'b0;
        end else if (last) begin
            exp_q.push_back({last, 1'b0, 8'h00, d});
        end else begin
            pend_valid = 1'b1;
            pend_byte  = d;
        end
    endtask

    task automatic send_byte(input logic last);
        @(posedge wr_clk);
        in_valid <= 1'b1;
        in_data  <= next_data;
        in_last  <= last;
        expect_byte(next_data, last);
        next_data = next_data + 8'd1;
        bytes_in++;
    endtask

    task automatic idle_wr(input int n);
        repeat (n) begin
            @(posedge wr_clk);
            in_valid <= 1'b0;
            in_last  <= 1'b0;
        end
    endtask

    task automatic send_packet(input int len, input bit gapped);
        int gap;
        for (int i = 0; i < len; i++) begin
            send_byte(i == len - 1);
            if (gapped) begin
                rand_bits(2, gap);
                idle_wr(gap + 1);  // keeps input slower than the drain
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || pend_valid) @(posedge rd_clk);
        repeat (12) @(posedge rd_clk);  // room for a stray byte to show
    endtask

    task automatic wait_quiet(input int n);
        int quiet;
        quiet = 0;
        while (quiet < n) begin
            @(negedge rd_clk);
            quiet = out_valid ? 0 : quiet + 1;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("test %s: %s, %0d errors", name,
                 (errors == start_errors) ? "pass" : "fail", errors - start_errors);
    endtask

    // scoreboard step at mid cycle, where out_data is stable
    always @(negedge rd_clk) begin
        if (rst_n && out_valid) begin
            bytes_out++;
            if (skip_mode && !second_pos) begin
                while (exp_q.size() != 0 && exp_q[0][7:0] != out_data) begin
                    void'(exp_q.pop_front());
                end
            end
            have_exp = (exp_q.size() != 0);
            if (have_exp) begin
                exp_data = second_pos ? exp_q[0][15:8] : exp_q[0][7:0];
                exp_last = exp_q[0][17] && (second_pos || !exp_q[0][16]);
                if (second_pos || !exp_q[0][16]) begin
                    void'(exp_q.pop_front());
                    second_pos = 1'b0;
                end else begin
                    second_pos = 1'b1;
                end
            end
        end
    end

    expected_present: assert property (@(posedge rd_clk) disable iff (!rst_n)
        out_valid |-> have_exp)
    else begin
        errors++;
        $display("output byte at %0t arrived with no byte left to expect", $time);
    end

    data_match: assert property (@(posedge rd_clk) disable iff (!rst_n)
        (out_valid && have_exp) |-> (out_data == exp_data && out_last == exp_last))
    else begin
        errors++;
        $display("Mismatch at %0t: expected data %h last %b, got data %h last %b", $time,
                 $sampled(exp_data), $sampled(exp_last), $sampled(out_data), $sampled(out_last));
    end

    idle_low: assert property (@(posedge rd_clk)
        idle_check |-> (!out_valid && !out_last && !overflow))
    else begin
        errors++;
        $display("outputs were not low after reset with no input, at %0t", $time);
    end

    ovf_low: assert property (@(posedge rd_clk) low_ovf_check |-> !overflow)
    else begin
        errors++;
        $display("overflow rose at %0t while the input was slower than the drain", $time);
    end

    ovf_sticky: assert property (@(posedge rd_clk) high_ovf_check |-> overflow)
    else begin
        errors++;
        $display("overflow fell at %0t before any reset", $time);
    end

    out_quiet: assert property (@(posedge rd_clk) quiet_check |-> (!out_valid && !out_last))
    else begin
        errors++;
        $display("output still active at %0t after the burst drained", $time);
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge rd_clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d rd_clk cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int len;
        int sent;
        int start_err;
        int odd_lens[5];
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_data        = '0;
        in_last        = 1'b0;
        lfsr           = 32'd99592;
        next_data      = 8'd0;
        pend_valid     = 1'b0;
        pend_byte      = 8'd0;
        second_pos     = 1'b0;
        exp_data       = 8'd0;
        exp_last       = 1'b0;
        have_exp       = 1'b0;
        skip_mode      = 1'b0;
        idle_check     = 1'b0;
        low_ovf_check  = 1'b0;
        high_ovf_check = 1'b0;
        quiet_check    = 1'b0;
        errors         = 0;
        bytes_in       = 0;
        bytes_out      = 0;
        odd_lens       = '{1, 3, 5, 1, 7};
        repeat (16) @(posedge rd_clk);
        rst_n <= 1'b1;

        start_err     = errors;
        idle_check    = 1'b1;
        low_ovf_check = 1'b1;
        repeat (50) @(posedge rd_clk);
        idle_check = 1'b0;
        report_test("1 idle after reset", start_err);

        start_err = errors;
        send_packet(24, 1'b1);
        wait_drain();
        report_test("2 even packet", start_err);

        start_err = errors;
        foreach (odd_lens[i]) send_packet(odd_lens[i], 1'b1);
        wait_drain();
        report_test("3 odd packets", start_err);

        start_err = errors;
        repeat (30) begin
            rand_bits(3, len);
            send_packet(len + 1, 1'b1);
        end
        wait_drain();
        low_ovf_check = 1'b0;
        report_test("4 random packets", start_err);

        // full rate input outruns the drain
        start_err = errors;
        skip_mode = 1'b1;
        sent      = 0;
        while (sent < BURST_BYTES) begin
            rand_bits(3, len);
            len = (len + 1 > BURST_BYTES - sent) ? BURST_BYTES - sent : len + 1;
            send_packet(len, 1'b0);
            sent += len;
        end
        idle_wr(4);
        overflow_set: assert (overflow)
        else begin
            errors++;
            $display("overflow did not rise during the full rate burst");
        end
        high_ovf_check = 1'b1;
        wait_quiet(40);
        quiet_check = 1'b1;
        repeat (20) @(posedge rd_clk);
        quiet_check = 1'b0;
        report_test("5 overflow burst", start_err);

        $display("summary: %0d bytes sent, %0d bytes received, %0d errors",
                 bytes_in, bytes_out, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hw/cdc_bridge_pkg.sv
hw/byte_pair_packer.sv
hw/gray_ptr_fifo.sv
hw/byte_unpacker.sv
hw/cdc_byte_bridge.sv
verif/tb_cdc_byte_bridge.sv
